// File: capture/capture_ring_buffer.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_ring_buffer
#(
    parameter int WIDTH     = `CAPTURE_WIDTH,
    parameter int DEPTH     = `CAPTURE_DEPTH,
    parameter int ADDR_BITS = `CAPTURE_ADDR_BITS
)
(
    input  logic             CLK,
    input  logic             RESET,
    input  logic             clear,
    input  logic             wr_en,
    input  logic             drop_oldest,
    input  logic             rd_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam logic [ADDR_BITS-1:0] LAST_ADDR  = (ADDR_BITS)'(DEPTH - 1);
    localparam logic [ADDR_BITS:0]   FULL_COUNT = (ADDR_BITS + 1)'(DEPTH);
    localparam logic [ADDR_BITS:0]   PRE_COUNT  = (ADDR_BITS + 1)'(`CAPTURE_PRE_LEN);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS:0]   count;
    logic [ADDR_BITS:0]   count_next;
    logic                 full;
    logic                 do_wr;
    logic                 do_rd;
    logic                 slide;

    function automatic logic [ADDR_BITS-1:0] next_ptr(input logic [ADDR_BITS-1:0] ptr);
        logic [ADDR_BITS-1:0] nxt;
        if (ptr == LAST_ADDR)
        begin
            nxt = '0;
        end
        else
        begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);

    // Show-ahead, oldest entry always on the output
    assign rd_data = mem[rd_ptr];

    assign do_wr = wr_en && !full;

    // Window full: new sample pushes out the oldest
    assign slide = do_wr && drop_oldest && (count == PRE_COUNT);

    assign do_rd = rd_en && !empty && !slide;

    always_comb
    begin
        count_next = count;
        if (do_wr && !slide && !do_rd)
        begin
            count_next = count + 1'b1;
        end
        else if (do_rd && !do_wr)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            // Read pointer moves on a pop or a slide
            if (slide || do_rd)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
        end
    end

endmodule

// File: capture/capture_sequencer.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_sequencer
(
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         arm,
    input  logic                         read,
    input  capture_pkg::sample_t         stage,
    input  logic                         match,
    output logic                         clear,
    output logic                         wr_en,
    output logic                         drop_oldest,
    output logic                         rd_en,
    input  logic                         buf_empty,
    output capture_pkg::capture_status_t status
);

    localparam int CNT_BITS = $clog2(`CAPTURE_POST_LEN + 1);
    localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(`CAPTURE_POST_LEN - 1);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_PRE,
        ST_POST,
        ST_DONE
    } state_t;

    state_t              state;
    logic [CNT_BITS-1:0] post_cnt;
    logic                capturing;

    assign capturing = (state == ST_PRE) || (state == ST_POST);

    assign clear       = arm;
    assign wr_en       = stage.valid && capturing;
    // Pre-trigger history slides until the trigger sample
    assign drop_oldest = (state == ST_PRE) && !match;
    assign rd_en       = read && (state == ST_DONE);

    assign status.armed     = capturing;
    assign status.triggered = (state == ST_POST) || (state == ST_DONE);
    assign status.done      = (state == ST_DONE);
    assign status.empty     = buf_empty;

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            state    <= ST_IDLE;
            post_cnt <= '0;
        end
        else if (arm)
        begin
            state    <= ST_PRE;
            post_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_PRE:
                begin
                    // Trigger sample counts as the first post sample
                    if (stage.valid && match)
                    begin
                        post_cnt <= CNT_BITS'(1);
                        if (`CAPTURE_POST_LEN == 1)
                        begin
                            state <= ST_DONE;
                        end
                        else
                        begin
                            state <= ST_POST;
                        end
                    end
                end
                ST_POST:
                begin
                    if (stage.valid)
                    begin
                        post_cnt <= post_cnt + 1'b1;
                        if (post_cnt == LAST_CNT)
                        begin
                            state <= ST_DONE;
                        end
                    end
                end
                default:
                begin
                    // Idle and done wait for the next arm
                    state <= state;
                end
            endcase
        end
    end

endmodule

// File: common/capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// Sample word width
`define CAPTURE_WIDTH 16

// Buffer entries, at least pre plus post lengths
`define CAPTURE_DEPTH 64

// Pointer width for the buffer
`define CAPTURE_ADDR_BITS 6

// History kept ahead of the trigger sample
`define CAPTURE_PRE_LEN 12

// Stored from the trigger sample onward, trigger included
`define CAPTURE_POST_LEN 20

`endif

// File: common/capture_pkg.sv
`include "capture_config.svh"

package capture_pkg;

    // One sample as it arrives from the probe
    typedef struct packed
    {
        logic                      valid;
        logic [`CAPTURE_WIDTH-1:0] data;
    } sample_t;

    // Pattern trigger setup, held stable while armed
    typedef struct packed
    {
        logic [`CAPTURE_WIDTH-1:0] pattern;
        // 1 means the bit takes part in the compare
        logic [`CAPTURE_WIDTH-1:0] mask;
        // Fire only on a match that follows a non-match
        logic                      edge_only;
    } trigger_cfg_t;

    // Host visible capture state
    typedef struct packed
    {
        logic armed;
        logic triggered;
        logic done;
        logic empty;
    } capture_status_t;

endpackage

// File: flist.f
+incdir+common
common/capture_pkg.sv
trigger/trigger_match.sv
capture/capture_ring_buffer.sv
capture/capture_sequencer.sv
logic/capture_top.sv
tests/capture_checks.sv
tests/capture_tb.sv

// File: logic/capture_top.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_top
(
    input  logic                         CLK,
    input  logic                         RESET,
    input  capture_pkg::sample_t         sample_in,
    input  capture_pkg::trigger_cfg_t    trig_cfg,
    input  logic                         arm,
    input  logic                         read,
    output logic [`CAPTURE_WIDTH-1:0]    read_data,
    output capture_pkg::capture_status_t status
);

    import capture_pkg::*;

    sample_t stage;
    logic    match;
    logic    clear;
    logic    wr_en;
    logic    drop_oldest;
    logic    rd_en;
    logic    buf_empty;

    trigger_match trigger_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .sample_in (sample_in),
        .trig_cfg  (trig_cfg),
        .stage     (stage),
        .match     (match)
    );

    capture_sequencer sequencer_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .arm         (arm),
        .read        (read),
        .stage       (stage),
        .match       (match),
        .clear       (clear),
        .wr_en       (wr_en),
        .drop_oldest (drop_oldest),
        .rd_en       (rd_en),
        .buf_empty   (buf_empty),
        .status      (status)
    );

    capture_ring_buffer
    #(
        .WIDTH     (`CAPTURE_WIDTH),
        .DEPTH     (`CAPTURE_DEPTH),
        .ADDR_BITS (`CAPTURE_ADDR_BITS)
    )
    buffer_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .clear       (clear),
        .wr_en       (wr_en),
        .drop_oldest (drop_oldest),
        .rd_en       (rd_en),
        .wr_data     (stage.data),
        .rd_data     (read_data),
        .empty       (buf_empty)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module capture_tb -f flist.f -o capture_sim

./obj_dir/capture_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "sim passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// File: tests/capture_checks.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_checks
(
    input  logic                         CLK,
    input  logic                         check_rd,
    input  logic [`CAPTURE_WIDTH-1:0]    exp_data,
    input  logic [`CAPTURE_WIDTH-1:0]    read_data,
    input  logic                         check_status,
    input  capture_pkg::capture_status_t exp_status,
    input  capture_pkg::capture_status_t status,
    output int                           errors,
    output int                           checks
);

    int error_count = 0;
    int check_count = 0;

    assign errors = error_count;
    assign checks = check_count;

    // Values are sampled at the edge, before the DUT updates
    always @(posedge CLK)
    begin
        if (check_rd)
        begin
            check_count = check_count + 1;
            assert (read_data == exp_data)
            else
            begin
                $display("Mismatch read_data: got %h, expected %h", read_data, exp_data);
                error_count = error_count + 1;
            end
        end
        if (check_status)
        begin
            check_count = check_count + 1;
            assert (status == exp_status)
            else
            begin
                $display("Mismatch status: got %h, expected %h", status, exp_status);
                error_count = error_count + 1;
            end
        end
    end

endmodule

// File: tests/capture_tb.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_tb;

    import capture_pkg::*;

    localparam int DONE_TIMEOUT = 400;
    localparam int READ_TIMEOUT = 100;
    localparam logic [`CAPTURE_WIDTH-1:0] PAT = 16'hA5C3;

    logic                      CLK = 1'b0;
    logic                      RESET;
    sample_t                   sample_in;
    trigger_cfg_t              trig_cfg;
    logic                      arm;
    logic                      read;
    logic [`CAPTURE_WIDTH-1:0] read_data;
    capture_status_t           status;

    logic                      check_rd;
    logic                      check_status;
    logic [`CAPTURE_WIDTH-1:0] exp_data;
    capture_status_t           exp_status;
    int                        errors;
    int                        checks;

    int seed = 74967;
    int fails = 0;
    int tests = 0;
    int last_total = 0;

    // Reference record
    // Phase is 0 idle, 1 pre, 2 post or 3 done
    logic [`CAPTURE_WIDTH-1:0] model_q[$];
    int                        phase;
    int                        post_n;
    logic                      model_prev;

    always #10 CLK = ~CLK;

    capture_top dut_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .sample_in (sample_in),
        .trig_cfg  (trig_cfg),
        .arm       (arm),
        .read      (read),
        .read_data (read_data),
        .status    (status)
    );

    capture_checks checks_i
    (
        .CLK          (CLK),
        .check_rd     (check_rd),
        .exp_data     (exp_data),
        .read_data    (read_data),
        .check_status (check_status),
        .exp_status   (exp_status),
        .status       (status),
        .errors       (errors),
        .checks       (checks)
    );

    task automatic tick();
        @(posedge CLK);
        #2;
    endtask

    function automatic logic [`CAPTURE_WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[`CAPTURE_WIDTH-1:0];
    endfunction

    function automatic logic is_hit(input logic [`CAPTURE_WIDTH-1:0] d);
        return ((d ^ trig_cfg.pattern) & trig_cfg.mask) == '0;
    endfunction

    // Flip the lowest compared bit if the word happens to hit
    function automatic logic [`CAPTURE_WIDTH-1:0] rand_miss();
        logic [`CAPTURE_WIDTH-1:0] d;
        d = rand_word();
        if (is_hit(d))
        begin
            d = d ^ (trig_cfg.mask & (~trig_cfg.mask + 1'b1));
        end
        return d;
    endfunction

    function automatic capture_status_t model_status();
        capture_status_t s;
        s.armed     = (phase == 1) || (phase == 2);
        s.triggered = (phase == 2) || (phase == 3);
        s.done      = (phase == 3);
        s.empty     = (model_q.size() == 0);
        return s;
    endfunction

    task automatic model_sample(input logic [`CAPTURE_WIDTH-1:0] d);
        logic fire;
        fire = is_hit(d) && (!trig_cfg.edge_only || !model_prev);
        if (phase == 1)
        begin
            model_q.push_back(d);
            if (fire)
            begin
                post_n = 1;
                phase  = 2;
            end
            else if (model_q.size() > `CAPTURE_PRE_LEN)
            begin
                model_q.delete(0);
            end
        end
        else if (phase == 2)
        begin
            model_q.push_back(d);
            post_n++;
            if (post_n == `CAPTURE_POST_LEN)
            begin
                phase = 3;
            end
        end
        model_prev = is_hit(d);
    endtask

    task automatic send_sample(input logic [`CAPTURE_WIDTH-1:0] d);
        sample_in.valid = 1'b1;
        sample_in.data  = d;
        model_sample(d);
        tick();
        sample_in.valid = 1'b0;
    endtask

    task automatic send_gap(input int n);
        repeat (n)
        begin
            sample_in.valid = 1'b0;
            sample_in.data  = rand_word();
            tick();
        end
    endtask

    task automatic send_misses(input int n);
        repeat (n) send_sample(rand_miss());
    endtask

    task automatic send_randoms(input int n);
        repeat (n) send_sample(rand_word());
    endtask

    task automatic arm_capture();
        sample_in.valid = 1'b0;
        arm = 1'b1;
        model_q.delete();
        phase  = 1;
        post_n = 0;
        tick();
        arm = 1'b0;
    endtask

    // One idle cycle lets the last sample reach memory first
    task automatic check_model_status();
        send_gap(1);
        exp_status   = model_status();
        check_status = 1'b1;
        tick();
        check_status = 1'b0;
    endtask

    task automatic read_ignored();
        read = 1'b1;
        tick();
        read = 1'b0;
    endtask

    task automatic wait_done();
        int i;
        i = 0;
        while (!status.done && i < DONE_TIMEOUT)
        begin
            tick();
            i++;
        end
        if (!status.done)
        begin
            $display("Timed out waiting for the capture to finish");
            fails++;
        end
    endtask

    task automatic read_record();
        int n;
        n = 0;
        while (model_q.size() > 0 && n < READ_TIMEOUT)
        begin
            if (status.empty)
            begin
                $display("Buffer went empty with %0d words still expected", model_q.size());
                fails++;
                model_q.delete();
            end
            else
            begin
                exp_data = model_q[0];
                model_q.delete(0);
                read     = 1'b1;
                check_rd = 1'b1;
                tick();
                read     = 1'b0;
                check_rd = 1'b0;
            end
            n++;
        end
        if (model_q.size() > 0)
        begin
            $display("Timed out reading the record");
            fails++;
        end
        check_model_status();
    endtask

    // Late samples land while done and must not reach the record
    task automatic finish_record();
        wait_done();
        send_randoms(6);
        read_record();
    endtask

    task automatic finish_test(input string name);
        int total;
        total = errors + fails;
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, total - last_total);
        last_total = total;
    endtask

    task automatic edge_stimulus();
        repeat (3) send_sample(PAT);
        arm_capture();
        repeat (4) send_sample(PAT);
        send_misses(3);
        repeat (4) send_sample(PAT);
        send_randoms(20);
    endtask

    initial
    begin
        sample_in    = '0;
        trig_cfg     = '0;
        arm          = 1'b0;
        read         = 1'b0;
        check_rd     = 1'b0;
        check_status = 1'b0;
        exp_data     = '0;
        exp_status   = '0;
        phase        = 0;
        post_n       = 0;
        model_prev   = 1'b0;
        RESET        = 1'b0;
        repeat (16) @(posedge CLK);
        #2;
        RESET = 1'b1;
        check_model_status();
        finish_test("reset state");

        trig_cfg.pattern   = PAT;
        trig_cfg.mask      = 16'hFFFF;
        trig_cfg.edge_only = 1'b0;
        arm_capture();
        check_model_status();
        send_misses(40);
        send_sample(PAT);
        check_model_status();
        send_randoms(25);
        finish_record();
        finish_test("level trigger after long run");

        arm_capture();
        send_misses(5);
        send_sample(PAT);
        send_randoms(24);
        finish_record();
        finish_test("early trigger");

        trig_cfg.edge_only = 1'b1;
        edge_stimulus();
        finish_record();
        trig_cfg.edge_only = 1'b0;
        edge_stimulus();
        finish_record();
        finish_test("edge and level mode");

        trig_cfg.pattern = 16'h3C00;
        trig_cfg.mask    = 16'hFF00;
        arm_capture();
        send_misses(10);
        send_sample(16'h3D00);
        send_sample(16'h2C5A);
        send_sample(16'h3C5A);
        send_randoms(22);
        finish_record();
        finish_test("mask don't care bits");

        trig_cfg.pattern = PAT;
        trig_cfg.mask    = 16'hFFFF;
        arm_capture();
        repeat (8)
        begin
            send_sample(rand_miss());
            send_gap(2);
        end
        read_ignored();
        check_model_status();
        send_sample(PAT);
        repeat (10)
        begin
            send_sample(rand_word());
            send_gap(1);
        end
        // Post-trigger phase, still short of done
        read_ignored();
        repeat (12)
        begin
            send_sample(rand_word());
            send_gap(1);
        end
        finish_record();
        finish_test("valid gaps and early reads");

        arm_capture();
        send_misses(6);
        send_sample(PAT);
        send_randoms(5);
        check_model_status();
        arm_capture();
        check_model_status();
        send_misses(15);
        send_sample(PAT);
        send_randoms(25);
        finish_record();
        finish_test("re-arm in post-trigger");

        $display("Tests %0d, checks %0d, errors %0d, other failures %0d",
                 tests, checks, errors, fails);
        if (errors == 0 && fails == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: trigger/trigger_match.sv
`timescale 1ns/1ps

module trigger_match
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  capture_pkg::sample_t       sample_in,
    input  capture_pkg::trigger_cfg_t  trig_cfg,
    output capture_pkg::sample_t       stage,
    output logic                       match
);

    logic hit;
    logic prev_hit;
    logic fire;

    // Masked compare, unmasked bits are don't care
    assign hit = ((sample_in.data ^ trig_cfg.pattern) & trig_cfg.mask) == '0;

    // Edge mode needs the previous valid sample to have missed
    always_comb
    begin
        fire = 1'b0;
        if (sample_in.valid && hit)
        begin
            if (trig_cfg.edge_only)
            begin
                fire = !prev_hit;
            end
            else
            begin
                fire = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        stage.data <= sample_in.data;
        if (!RESET)
        begin
            stage.valid <= 1'b0;
            match       <= 1'b0;
            prev_hit    <= 1'b0;
        end
        else
        begin
            stage.valid <= sample_in.valid;
            match       <= fire;
            // Gaps keep the last state, so no false edges
            if (sample_in.valid)
            begin
                prev_hit <= hit;
            end
        end
    end

endmodule
